//--- uart_console_top.f
+incdir+.
console_pkg.sv
baud_tick_gen.sv
uart_tx.sv
message_rom.sv
request_arbiter.sv
byte_sequencer.sv
uart_console_top.sv
uart_console_chk.sv
tb_uart_console.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_uart_console
FILELIST ?= uart_console_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_uart_console.sv
`default_nettype none

`include "console_settings.svh"

module tb_uart_console;

        timeunit 1ns;
        timeprecision 1ps;

        import console_pkg::*;

        localparam int BIT_CLKS = `CONSOLE_CLK_FREQ / `CONSOLE_BAUD;
        localparam int TEXT_W = 8 * `CONSOLE_BANNER_LEN;
        // About 212 bytes at 101 clocks each plus waits and margin
        localparam int TIMEOUT_CYCLES = 40000;

        logic                            clk = 1'b0;
        logic                            rst_n;
        logic                            pc_req;
        logic                            alu_req;
        logic                            fib_req;
        logic                            banner_req;
        logic                            mode_cpu_req;
        logic                            mode_alu_req;
        logic                            mode_fib_req;
        logic                            newline_req;
        logic                            key_req;
        logic [8*`CONSOLE_PC_BYTES-1:0]  pc;
        logic [8*`CONSOLE_ALU_BYTES-1:0] alu;
        logic [8*`CONSOLE_FIB_BYTES-1:0] fib;
        logic [7:0]                      key_data;
        logic                            txd;
        logic                            busy;

        logic [7:0] exp_q[$];           // Bytes still to arrive on txd
        string      name_q[$];
        string      test_name = "none";
        integer     seed = 97121;
        int         cycles = 0;

        always #50 clk = ~clk;

        uart_console_top UUT (
                .clk          (clk),
                .rst_n        (rst_n),
                .pc_req       (pc_req),
                .alu_req      (alu_req),
                .fib_req      (fib_req),
                .banner_req   (banner_req),
                .mode_cpu_req (mode_cpu_req),
                .mode_alu_req (mode_alu_req),
                .mode_fib_req (mode_fib_req),
                .newline_req  (newline_req),
                .key_req      (key_req),
                .pc           (pc),
                .alu          (alu),
                .fib          (fib),
                .key_data     (key_data),
                .txd          (txd),
                .busy         (busy)
        );

        task automatic stop_with_error(input string what);
                $display("%s", what);
                $display("sim failed");
                $fatal(1, "run stopped at the first error");
        endtask

        task automatic check_byte(input string name, input logic [7:0] exp,
                                  input logic [7:0] act);
                assert (act === exp) else begin
                        stop_with_error($sformatf("ERR %s expected 0x%02h actual 0x%02h",
                                                  name, exp, act));
                end
        endtask

        ////////////////////////////////////////////////////////////
        // Expected byte stream
        ////////////////////////////////////////////////////////////
        task automatic expect_byte(input logic [7:0] b);
                exp_q.push_back(b);
                name_q.push_back(test_name);
        endtask

        // Value right aligned and sent MSB first before CR LF
        task automatic expect_value(input logic [63:0] value, input int nbytes);
                for (int i = nbytes - 1; i >= 0; i--)
                        expect_byte(value[8*i +: 8]);
                expect_byte(`CONSOLE_CR);
                expect_byte(`CONSOLE_LF);
        endtask

        task automatic expect_text(input logic [TEXT_W-1:0] text, input int len);
                logic [TEXT_W-1:0] rest;
                rest = text << (8 * (TEXT_W / 8 - len)); // First char to the top
                for (int i = 0; i < len; i++) begin
                        expect_byte(rest[TEXT_W-1 -: 8]);
                        rest = rest << 8;
                end
        endtask

        ////////////////////////////////////////////////////////////
        // Stimulus helpers
        ////////////////////////////////////////////////////////////
        task automatic next_drive();
                @(posedge clk);
                #10;
        endtask

        task automatic clear_requests();
                pc_req = 1'b0;
                alu_req = 1'b0;
                fib_req = 1'b0;
                banner_req = 1'b0;
                mode_cpu_req = 1'b0;
                mode_alu_req = 1'b0;
                mode_fib_req = 1'b0;
                newline_req = 1'b0;
                key_req = 1'b0;
        endtask

        task automatic raise_request(input source_t src);
                case (src)
                SRC_PC:       pc_req = 1'b1;
                SRC_ALU:      alu_req = 1'b1;
                SRC_FIB:      fib_req = 1'b1;
                SRC_BANNER:   banner_req = 1'b1;
                SRC_MODE_CPU: mode_cpu_req = 1'b1;
                SRC_MODE_ALU: mode_alu_req = 1'b1;
                SRC_MODE_FIB: mode_fib_req = 1'b1;
                SRC_NEWLINE:  newline_req = 1'b1;
                SRC_KEY:      key_req = 1'b1;
                default: ;
                endcase
        endtask

        task automatic pulse(input source_t src);
                next_drive();
                raise_request(src);
                next_drive();
                clear_requests();
        endtask

        task automatic wait_idle();
                repeat (2) @(negedge clk);
                while (busy)
                        @(negedge clk);
                assert (exp_q.size() == 0) else begin
                        stop_with_error($sformatf("ERR %s expected 0 bytes outstanding actual %0d",
                                                  test_name, exp_q.size()));
                end
                next_drive();
        endtask

        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles >= TIMEOUT_CYCLES)
                        stop_with_error($sformatf("timeout after %0d cycles, output never finished",
                                                  cycles));
        end

        ////////////////////////////////////////////////////////////
        // Serial receiver sampling mid-bit
        ////////////////////////////////////////////////////////////
        initial begin : serial_receiver
                logic [7:0] data;
                logic [7:0] exp;
                string      name;
                forever begin
                        @(negedge clk);
                        if (rst_n === 1'b1 && txd === 1'b0) begin
                                repeat (BIT_CLKS / 2 - 1) @(negedge clk);
                                assert (txd === 1'b0)
                                        else stop_with_error("start bit ended before its middle");
                                for (int i = 0; i < 8; i++) begin
                                        repeat (BIT_CLKS) @(negedge clk);
                                        data[i] = txd;  // LSB first
                                end
                                repeat (BIT_CLKS) @(negedge clk);
                                assert (txd === 1'b1)
                                        else stop_with_error("stop bit was low");
                                assert (exp_q.size() > 0) else begin
                                        stop_with_error($sformatf("byte 0x%02h arrived unexpected",
                                                                  data));
                                end
                                exp = exp_q.pop_front();
                                name = name_q.pop_front();
                                check_byte(name, exp, data);
                        end
                end
        end

        initial begin : stimulus
                logic [7:0] key_val;
                rst_n = 1'b0;
                clear_requests();
                pc = '0;
                alu = '0;
                fib = '0;
                key_data = '0;
                repeat (8) @(posedge clk);
                #10 rst_n = 1'b1;

                test_name = "reset_idle";
                repeat (20) begin
                        @(negedge clk);
                        assert (txd === 1'b1 && busy === 1'b0) else begin
                                stop_with_error($sformatf(
                                        "ERR %s expected txd 1 busy 0 actual txd %b busy %b",
                                        test_name, txd, busy));
                        end
                end
                next_drive();

                test_name = "pc_report";
                pc = {$random(seed), $random(seed)};
                expect_value(pc, `CONSOLE_PC_BYTES);
                pulse(SRC_PC);
                wait_idle();

                test_name = "alu_report";
                alu = 24'($random(seed));
                expect_value(64'(alu), `CONSOLE_ALU_BYTES);
                pulse(SRC_ALU);
                wait_idle();

                test_name = "fib_report";
                fib = {$random(seed), $random(seed)};
                expect_value(fib, `CONSOLE_FIB_BYTES);
                pulse(SRC_FIB);
                wait_idle();

                test_name = "banner_text";
                expect_text(BANNER_TEXT, `CONSOLE_BANNER_LEN);
                pulse(SRC_BANNER);
                wait_idle();

                test_name = "mode_cpu_text";
                expect_text(TEXT_W'(MODE_CPU_TEXT), `CONSOLE_MODE_LEN);
                pulse(SRC_MODE_CPU);
                wait_idle();

                test_name = "mode_alu_text";
                expect_text(TEXT_W'(MODE_ALU_TEXT), `CONSOLE_MODE_LEN);
                pulse(SRC_MODE_ALU);
                wait_idle();

                test_name = "mode_fib_text";
                expect_text(TEXT_W'(MODE_FIB_TEXT), `CONSOLE_MODE_LEN);
                pulse(SRC_MODE_FIB);
                wait_idle();

                // Key byte latched on the request and kept
                test_name = "key_echo";
                key_val = 8'($random(seed));
                expect_byte(key_val);
                key_data = key_val;
                pulse(SRC_KEY);
                key_data = ~key_val;
                wait_idle();

                test_name = "newline";
                expect_byte(`CONSOLE_LF);
                pulse(SRC_NEWLINE);
                wait_idle();

                test_name = "same_cycle_priority";
                alu = 24'($random(seed));
                key_val = 8'($random(seed));
                expect_value(64'(alu), `CONSOLE_ALU_BYTES);
                expect_text(TEXT_W'(MODE_FIB_TEXT), `CONSOLE_MODE_LEN);
                expect_byte(key_val);
                next_drive();
                key_data = key_val;
                raise_request(SRC_KEY);
                raise_request(SRC_MODE_FIB);
                raise_request(SRC_ALU);
                next_drive();
                clear_requests();
                wait_idle();

                // Two newline pulses during a report merge into one
                test_name = "request_during_report";
                pc = {$random(seed), $random(seed)};
                expect_value(pc, `CONSOLE_PC_BYTES);
                expect_byte(`CONSOLE_LF);
                pulse(SRC_PC);
                while (exp_q.size() > 9)
                        @(negedge clk);
                pulse(SRC_NEWLINE);
                pulse(SRC_NEWLINE);
                wait_idle();

                if (exp_q.size() == 0 && !busy) begin
                        $display("sim passed");
                        $finish;
                end else begin
                        stop_with_error("bytes still expected or console busy at the end");
                end
        end

endmodule

`default_nettype wire

//--- uart_console_chk.sv
`default_nettype none

module uart_console_chk (
        input logic                  clk,
        input logic                  rst_n,
        input console_pkg::tx_state_t tx_state,
        input logic                  txd,
        input logic                  byte_valid,
        input logic                  byte_ready,
        input logic [7:0]            tx_byte,
        input logic                  seq_idle,
        input console_pkg::source_t  grant
);

        timeunit 1ns;
        timeprecision 1ps;

        import console_pkg::*;

        ////////////////////////////////////////////////////////////
        // Serial line
        ////////////////////////////////////////////////////////////
        idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
                (tx_state == TX_IDLE) |-> txd)
                else $error("txd low while the transmitter is idle");

        stop_bit_high: assert property (@(posedge clk) disable iff (!rst_n)
                (tx_state == TX_STOP) |-> txd)
                else $error("stop bit low");

        ////////////////////////////////////////////////////////////
        // Handshakes
        ////////////////////////////////////////////////////////////
        grant_accepted: assert property (@(posedge clk) disable iff (!rst_n)
                (grant != SRC_NONE) |-> seq_idle ##1 !seq_idle)
                else $error("grant issued while the sequencer was busy or never taken");

        valid_held: assert property (@(posedge clk) disable iff (!rst_n)
                (byte_valid && !byte_ready) |=> (byte_valid && $stable(tx_byte)))
                else $error("byte_valid or tx_byte changed before the transfer");

endmodule

// Transmitter side with the arbiter inputs tied inactive
bind uart_tx uart_console_chk u_tx_chk (
        .clk(clk), .rst_n(rst_n), .tx_state(state), .txd(txd),
        .byte_valid(byte_valid), .byte_ready(byte_ready), .tx_byte(tx_byte),
        .seq_idle(1'b1), .grant(console_pkg::SRC_NONE)
);

bind request_arbiter uart_console_chk u_arb_chk (
        .clk(clk), .rst_n(rst_n), .tx_state(console_pkg::TX_IDLE), .txd(1'b1),
        .byte_valid(1'b0), .byte_ready(1'b1), .tx_byte(8'd0),
        .seq_idle(seq_idle), .grant(grant)
);

`default_nettype wire

//--- uart_console_top.sv
`default_nettype none

`include "console_settings.svh"

module uart_console_top (
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            pc_req,
        input  logic                            alu_req,
        input  logic                            fib_req,
        input  logic                            banner_req,
        input  logic                            mode_cpu_req,
        input  logic                            mode_alu_req,
        input  logic                            mode_fib_req,
        input  logic                            newline_req,
        input  logic                            key_req,
        input  logic [8*`CONSOLE_PC_BYTES-1:0]  pc,
        input  logic [8*`CONSOLE_ALU_BYTES-1:0] alu,
        input  logic [8*`CONSOLE_FIB_BYTES-1:0] fib,
        input  logic [7:0]                      key_data,
        output logic                            txd,
        output logic                            busy
);

        import console_pkg::*;

        source_t                  grant;
        source_t                  msg_sel;
        logic [7:0]               key_byte;
        logic [7:0]               msg_byte;
        logic [7:0]               tx_byte;
        logic [`CONSOLE_IDX_W-1:0] msg_index;
        logic [`CONSOLE_IDX_W-1:0] msg_len;
        logic                     pending_any;
        logic                     seq_idle;
        logic                     byte_valid;
        logic                     byte_ready;
        logic                     tx_active;

        assign busy = pending_any || !seq_idle || tx_active;

        request_arbiter u_arb (
                .clk(clk), .rst_n(rst_n),
                .pc_req(pc_req), .alu_req(alu_req), .fib_req(fib_req),
                .banner_req(banner_req), .mode_cpu_req(mode_cpu_req),
                .mode_alu_req(mode_alu_req), .mode_fib_req(mode_fib_req),
                .newline_req(newline_req), .key_req(key_req), .key_data(key_data),
                .seq_idle(seq_idle), .grant(grant), .key_byte(key_byte),
                .pending_any(pending_any)
        );

        byte_sequencer u_seq (
                .clk(clk), .rst_n(rst_n), .grant(grant),
                .pc(pc), .alu(alu), .fib(fib), .key_byte(key_byte),
                .msg_byte(msg_byte), .msg_len(msg_len), .msg_sel(msg_sel),
                .msg_index(msg_index), .byte_valid(byte_valid), .tx_byte(tx_byte),
                .byte_ready(byte_ready), .seq_idle(seq_idle)
        );

        message_rom u_rom (
                .msg_sel(msg_sel), .msg_index(msg_index),
                .msg_byte(msg_byte), .msg_len(msg_len)
        );

        uart_tx u_tx (
                .clk(clk), .rst_n(rst_n), .byte_valid(byte_valid), .tx_byte(tx_byte),
                .byte_ready(byte_ready), .txd(txd), .tx_active(tx_active)
        );

endmodule

`default_nettype wire

//--- byte_sequencer.sv
`default_nettype none

`include "console_settings.svh"

module byte_sequencer (
        input  logic                          clk,
        input  logic                          rst_n,
        input  console_pkg::source_t          grant,
        input  logic [8*`CONSOLE_PC_BYTES-1:0]  pc,
        input  logic [8*`CONSOLE_ALU_BYTES-1:0] alu,
        input  logic [8*`CONSOLE_FIB_BYTES-1:0] fib,
        input  logic [7:0]                    key_byte,
        input  logic [7:0]                    msg_byte,
        input  logic [`CONSOLE_IDX_W-1:0]     msg_len,
        output console_pkg::source_t          msg_sel,
        output logic [`CONSOLE_IDX_W-1:0]     msg_index,
        output logic                          byte_valid,
        output logic [7:0]                    tx_byte,
        input  logic                          byte_ready,
        output logic                          seq_idle
);

        import console_pkg::*;

        localparam int SHIFT_W = 64;
        localparam int IDX_W = `CONSOLE_IDX_W;
        localparam logic [IDX_W-1:0] PC_COUNT = `CONSOLE_PC_BYTES + 2;
        localparam logic [IDX_W-1:0] ALU_COUNT = `CONSOLE_ALU_BYTES + 2;
        localparam logic [IDX_W-1:0] FIB_COUNT = `CONSOLE_FIB_BYTES + 2;
        localparam logic [IDX_W-1:0] LAST = 1;
        localparam logic [IDX_W-1:0] LF_POS = 2;
        localparam logic [IDX_W-1:0] CR_POS = 3;

        source_t            src;
        logic [SHIFT_W-1:0] shift;
        logic [SHIFT_W-1:0] snapshot;
        logic [IDX_W-1:0]   remaining;   // Bytes left, the one on valid included
        logic [IDX_W-1:0]   start_count;
        logic [7:0]         first_byte;
        logic               start;
        logic               xfer;
        logic               is_report;

        assign seq_idle = (remaining == '0);
        assign start = seq_idle && (grant != SRC_NONE);
        assign xfer = byte_valid && byte_ready;
        assign msg_sel = seq_idle ? grant : src; // ROM sees the grant for its length
        assign is_report = (src == SRC_PC) || (src == SRC_ALU) || (src == SRC_FIB);

        ////////////////////////////////////////////////////////////
        // Snapshot of the granted source, MSB aligned
        ////////////////////////////////////////////////////////////
        always_comb begin
                snapshot = '0;
                start_count = msg_len;
                case (grant)
                SRC_PC: begin
                        snapshot[SHIFT_W-1 -: 8*`CONSOLE_PC_BYTES] = pc;
                        start_count = PC_COUNT;
                end
                SRC_ALU: begin
                        snapshot[SHIFT_W-1 -: 8*`CONSOLE_ALU_BYTES] = alu;
                        start_count = ALU_COUNT;
                end
                SRC_FIB: begin
                        snapshot[SHIFT_W-1 -: 8*`CONSOLE_FIB_BYTES] = fib;
                        start_count = FIB_COUNT;
                end
                SRC_NEWLINE: begin
                        snapshot[SHIFT_W-1 -: 8] = `CONSOLE_LF;
                        start_count = LAST;
                end
                SRC_KEY: begin
                        snapshot[SHIFT_W-1 -: 8] = key_byte;
                        start_count = LAST;
                end
                default: ;                      // Texts come from the ROM
                endcase
                first_byte = (start_count == msg_len) ? msg_byte : snapshot[SHIFT_W-1 -: 8];
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        src <= SRC_NONE;
                        remaining <= '0;
                        msg_index <= '0;
                        byte_valid <= 1'b0;
                end else if (start) begin
                        src <= grant;
                        remaining <= start_count;
                        msg_index <= LAST;      // Byte 0 goes out with the grant
                        byte_valid <= 1'b1;
                end else if (xfer) begin
                        remaining <= remaining - LAST;
                        if (remaining == LAST) begin
                                src <= SRC_NONE;
                                msg_index <= '0;
                                byte_valid <= 1'b0;
                        end else begin
                                msg_index <= msg_index + LAST;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (start) begin
                        tx_byte <= first_byte;
                        shift <= snapshot << 8;
                end else if (xfer && remaining != LAST) begin
                        if (!is_report) begin
                                tx_byte <= msg_byte;
                        end else if (remaining == CR_POS) begin
                                tx_byte <= `CONSOLE_CR;
                        end else if (remaining == LF_POS) begin
                                tx_byte <= `CONSOLE_LF;
                        end else begin
                                tx_byte <= shift[SHIFT_W-1 -: 8];
                                shift <= shift << 8;
                        end
                end
        end

endmodule

`default_nettype wire

//--- request_arbiter.sv
`default_nettype none

module request_arbiter (
        input  logic                 clk,
        input  logic                 rst_n,
        input  logic                 pc_req,
        input  logic                 alu_req,
        input  logic                 fib_req,
        input  logic                 banner_req,
        input  logic                 mode_cpu_req,
        input  logic                 mode_alu_req,
        input  logic                 mode_fib_req,
        input  logic                 newline_req,
        input  logic                 key_req,
        input  logic [7:0]           key_data,
        input  logic                 seq_idle,
        output console_pkg::source_t grant,
        output logic [7:0]           key_byte,
        output logic                 pending_any
);

        import console_pkg::*;

        localparam int NUM_REQ = 9;

        logic [NUM_REQ-1:0] req_vec; // Bit i belongs to source i + 1
        logic [NUM_REQ-1:0] pending;
        logic [NUM_REQ-1:0] served;

        assign req_vec = {key_req, newline_req, mode_fib_req, mode_alu_req, mode_cpu_req,
                          banner_req, fib_req, alu_req, pc_req};
        assign pending_any = |pending;

        always_comb begin
                grant = SRC_NONE;
                served = '0;
                if (seq_idle) begin
                        for (int i = NUM_REQ - 1; i >= 0; i--) begin
                                if (pending[i])
                                        grant = source_t'(4'(i + 1)); // Lowest index wins
                        end
                end
                if (grant != SRC_NONE)
                        served[int'(grant) - 1] = 1'b1;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        pending <= '0;
                else
                        pending <= (pending & ~served) | req_vec; // Repeats merge
        end

        always_ff @(posedge clk) begin
                if (key_req)
                        key_byte <= key_data;
        end

endmodule

`default_nettype wire

//--- message_rom.sv
`default_nettype none

`include "console_settings.svh"

module message_rom (
        input  console_pkg::source_t           msg_sel,
        input  logic [`CONSOLE_IDX_W-1:0]      msg_index,
        output logic [7:0]                     msg_byte,
        output logic [`CONSOLE_IDX_W-1:0]      msg_len
);

        import console_pkg::*;

        localparam int TEXT_W = 8 * `CONSOLE_BANNER_LEN;
        localparam logic [`CONSOLE_IDX_W-1:0] BANNER_LEN = `CONSOLE_BANNER_LEN;
        localparam logic [`CONSOLE_IDX_W-1:0] MODE_LEN = `CONSOLE_MODE_LEN;

        logic [TEXT_W-1:0] text; // Selected text, right aligned
        int                slot;

        always_comb begin
                text = '0;
                msg_len = '0;
                case (msg_sel)
                SRC_BANNER: begin
                        text = BANNER_TEXT;
                        msg_len = BANNER_LEN;
                end
                SRC_MODE_CPU: begin
                        text = TEXT_W'(MODE_CPU_TEXT);
                        msg_len = MODE_LEN;
                end
                SRC_MODE_ALU: begin
                        text = TEXT_W'(MODE_ALU_TEXT);
                        msg_len = MODE_LEN;
                end
                SRC_MODE_FIB: begin
                        text = TEXT_W'(MODE_FIB_TEXT);
                        msg_len = MODE_LEN;
                end
                default: ;
                endcase

                // Character 0 sits in the top byte of the message
                slot = int'(msg_len) - 1 - int'(msg_index);
                msg_byte = (slot >= 0) ? text[8*slot +: 8] : 8'd0;
        end

endmodule

`default_nettype wire

//--- uart_tx.sv
`default_nettype none

module uart_tx (
        input  logic       clk,
        input  logic       rst_n,
        input  logic       byte_valid,
        input  logic [7:0] tx_byte,
        output logic       byte_ready,
        output logic       txd,
        output logic       tx_active
);

        import console_pkg::*;

        tx_state_t  state;
        logic [2:0] bit_cnt;
        logic [7:0] shift;
        logic       tick;

        assign byte_ready = (state == TX_IDLE);
        assign tx_active = (state != TX_IDLE);

        baud_tick_gen u_baud (
                .clk    (clk),
                .rst_n  (rst_n),
                .enable (tx_active),
                .tick   (tick)
        );

        ////////////////////////////////////////////////////////////
        // Frame FSM, start low, 8 data LSB first, stop high
        ////////////////////////////////////////////////////////////
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= TX_IDLE;
                        bit_cnt <= '0;
                        txd <= 1'b1;
                end else begin
                        case (state)
                        TX_IDLE: if (byte_valid) begin
                                state <= TX_START;
                                txd <= 1'b0;
                        end
                        TX_START: if (tick) begin
                                state <= TX_DATA;
                                txd <= shift[0];
                                bit_cnt <= '0;
                        end
                        TX_DATA: if (tick) begin
                                if (bit_cnt == 3'd7) begin
                                        state <= TX_STOP;
                                        txd <= 1'b1;
                                end else begin
                                        txd <= shift[0];
                                        bit_cnt <= bit_cnt + 3'd1;
                                end
                        end
                        TX_STOP: if (tick) state <= TX_IDLE;
                        default: state <= TX_IDLE;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (byte_valid && byte_ready)
                        shift <= tx_byte;
                else if (tick && (state == TX_START || state == TX_DATA))
                        shift <= {1'b0, shift[7:1]}; // Next bit to the bottom
        end

endmodule

`default_nettype wire

//--- baud_tick_gen.sv
`default_nettype none

`include "console_settings.svh"

module baud_tick_gen (
        input  logic clk,
        input  logic rst_n,
        input  logic enable,
        output logic tick
);

        localparam logic [32:0] CLK_FREQ = 33'(`CONSOLE_CLK_FREQ);
        localparam logic [32:0] BAUD = 33'(`CONSOLE_BAUD);

        logic [32:0] acc;
        logic [32:0] acc_sum;

        assign acc_sum = acc + BAUD;
        assign tick = enable && (acc_sum >= CLK_FREQ); // Wrap of the phase

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        acc <= '0;
                end else if (!enable) begin
                        acc <= '0;              // Fresh phase for each frame
                end else if (tick) begin
                        acc <= acc_sum - CLK_FREQ;
                end else begin
                        acc <= acc_sum;
                end
        end

endmodule

`default_nettype wire

//--- console_pkg.sv
`default_nettype none

`include "console_settings.svh"

package console_pkg;

        // Granted source, PC has the highest priority
        typedef enum logic [3:0] {
                SRC_NONE,
                SRC_PC,
                SRC_ALU,
                SRC_FIB,
                SRC_BANNER,
                SRC_MODE_CPU,
                SRC_MODE_ALU,
                SRC_MODE_FIB,
                SRC_NEWLINE,
                SRC_KEY
        } source_t;

        typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

        ////////////////////////////////////////////////////////////
        // Fixed texts, first character in the top byte
        ////////////////////////////////////////////////////////////
        localparam logic [8*`CONSOLE_BANNER_LEN-1:0] BANNER_TEXT = {
                "Terminal console online. Choose I, A or B mode", `CONSOLE_CR, `CONSOLE_LF};
        localparam logic [8*`CONSOLE_MODE_LEN-1:0] MODE_CPU_TEXT = {
                "Mode I: CPU program counter ", `CONSOLE_CR, `CONSOLE_LF};
        localparam logic [8*`CONSOLE_MODE_LEN-1:0] MODE_ALU_TEXT = {
                "Mode A: ALU result display  ", `CONSOLE_CR, `CONSOLE_LF};
        localparam logic [8*`CONSOLE_MODE_LEN-1:0] MODE_FIB_TEXT = {
                "Mode B: Fibonacci sequence  ", `CONSOLE_CR, `CONSOLE_LF};

endpackage

`default_nettype wire

//--- console_settings.svh
`ifndef CONSOLE_SETTINGS_SVH
`define CONSOLE_SETTINGS_SVH

// Clock and line rate
`define CONSOLE_CLK_FREQ 10000000
`define CONSOLE_BAUD 1000000

// Value report sizes in bytes
`define CONSOLE_PC_BYTES 8
`define CONSOLE_ALU_BYTES 3
`define CONSOLE_FIB_BYTES 8

// Message index and length width
`define CONSOLE_IDX_W 6

// Message lengths including CR LF
`define CONSOLE_BANNER_LEN 48
`define CONSOLE_MODE_LEN 30

// Line end characters
`define CONSOLE_CR 8'd13
`define CONSOLE_LF 8'd10

`endif
